// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 64;

    // RV64I major opcodes kept by the core
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b               // LUI result is the U immediate
    } alu_op_t;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    typedef enum logic {src_a_rs1, src_a_pc} src_a_sel_t;

    typedef enum logic {src_b_rs2, src_b_imm} src_b_sel_t;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_t;

    typedef enum logic [1:0] {npc_seq, npc_target, npc_alu} next_pc_sel_t;

endpackage

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic [31:0]              instr,
    input  logic                     zero,
    input  logic                     lt,
    input  logic                     ltu,
    input  logic                     reset,
    output rv_pkg::alu_op_t          alu_op,
    output rv_pkg::imm_fmt_t         imm_fmt,
    output rv_pkg::src_a_sel_t       src_a_sel,
    output rv_pkg::src_b_sel_t       src_b_sel,
    output rv_pkg::wb_sel_t          wb_sel,
    output rv_pkg::next_pc_sel_t     next_pc_sel,
    output logic                     rd_write_en,
    output logic                     mem_write_en
);

    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_we;
    logic       mem_we;
    logic       taken;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Branch condition from the flags of rs1 - rs2
    always_comb begin
        case (funct3)
            3'b000:  taken = zero;      // BEQ
            3'b001:  taken = !zero;     // BNE
            3'b100:  taken = lt;        // BLT
            3'b101:  taken = !lt;       // BGE
            3'b110:  taken = ltu;
            3'b111:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        alu_op      = alu_add;
        imm_fmt     = imm_i;
        src_a_sel   = src_a_rs1;
        src_b_sel   = src_b_rs2;
        wb_sel      = wb_alu;
        next_pc_sel = npc_seq;
        rd_we       = 1'b0;
        mem_we      = 1'b0;
        case (opcode)
            op_reg: begin
                rd_we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                case (funct3)
                    3'b000:  alu_op = (funct7 == 7'b0100000) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_imm: begin
                src_b_sel = src_b_imm;
                rd_we     = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: rd_we = 1'b0;         // Immediate shifts not kept
                endcase
            end
            op_load: begin
                src_b_sel = src_b_imm;
                wb_sel    = wb_mem;
                rd_we     = (funct3 == 3'b011);    // LD only
            end
            op_store: begin
                imm_fmt   = imm_s;
                src_b_sel = src_b_imm;
                mem_we    = (funct3 == 3'b011);    // SD only
            end
            op_branch: begin
                imm_fmt     = imm_b;
                alu_op      = alu_sub;
                next_pc_sel = taken ? npc_target : npc_seq;
            end
            op_jal: begin
                imm_fmt     = imm_j;
                wb_sel      = wb_pc4;
                next_pc_sel = npc_target;
                rd_we       = 1'b1;
            end
            op_jalr: begin
                src_b_sel   = src_b_imm;
                wb_sel      = wb_pc4;
                next_pc_sel = npc_alu;
                rd_we       = 1'b1;
            end
            op_lui: begin
                imm_fmt   = imm_u;
                src_b_sel = src_b_imm;
                alu_op    = alu_pass_b;
                rd_we     = 1'b1;
            end
            op_auipc: begin
                imm_fmt   = imm_u;
                src_a_sel = src_a_pc;
                src_b_sel = src_b_imm;
                rd_we     = 1'b1;
            end
            default: ;                             // Unknown opcode retires as a nop
        endcase
    end

    assign rd_write_en  = rd_we && !reset;
    assign mem_write_en = mem_we && !reset;

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [31:0]              instr,
    input  rv_pkg::imm_fmt_t         imm_fmt,
    output logic [rv_pkg::xlen-1:0]  imm
);

    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            imm_s: begin
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            imm_b: begin
                // Branch offsets are in half-words
                imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_u: begin
                imm = {{(xlen-32){sign}}, instr[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                     clk,
    input  logic [4:0]               rs1_addr,
    input  logic [4:0]               rs2_addr,
    input  logic [4:0]               rd_addr,
    input  logic [rv_pkg::xlen-1:0]  rd_data,
    input  logic                     rd_write_en,
    output logic [rv_pkg::xlen-1:0]  rs1_data,
    output logic [rv_pkg::xlen-1:0]  rs2_data
);

    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (rd_write_en && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == 5'd0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_pkg::xlen-1:0]  pc,
    input  logic [rv_pkg::xlen-1:0]  rs2_data,
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  rv_pkg::src_a_sel_t       src_a_sel,
    input  rv_pkg::src_b_sel_t       src_b_sel,
    input  rv_pkg::alu_op_t          alu_op,
    output logic [rv_pkg::xlen-1:0]  alu_result,
    output logic                     zero,
    output logic                     lt,
    output logic                     ltu
);

    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] diff;
    logic [5:0]      shamt;

    assign op_a  = (src_a_sel == src_a_pc)  ? pc  : rs1_data;
    assign op_b  = (src_b_sel == src_b_imm) ? imm : rs2_data;
    assign diff  = op_a - op_b;
    assign shamt = op_b[5:0];                            // RV64 shifts use 6 bits

    // Flags feed both SLT/SLTU and branch resolution
    assign zero = (diff == '0);
    assign lt   = $signed(op_a) < $signed(op_b);
    assign ltu  = op_a < op_b;

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = diff;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, lt};
            alu_sltu:   alu_result = {{(xlen-1){1'b0}}, ltu};
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = $signed(op_a) >>> shamt;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int dmem_words = 256                       // Power of two
) (
    input  logic                     clk,
    input  logic [rv_pkg::xlen-1:0]  addr,
    input  logic [rv_pkg::xlen-1:0]  wdata,
    input  logic                     mem_write_en,
    output logic [rv_pkg::xlen-1:0]  rdata
);

    import rv_pkg::*;

    localparam int idx_w = $clog2(dmem_words);

    logic [xlen-1:0]  mem [dmem_words];
    logic [idx_w-1:0] word_idx;

    // Doubleword index wraps at the depth
    assign word_idx = addr[idx_w+2:3];

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write_en) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];                        // Asynchronous read

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  logic [rv_pkg::xlen-1:0]  alu_result,
    input  rv_pkg::next_pc_sel_t     next_pc_sel,
    output logic [rv_pkg::xlen-1:0]  pc,
    output logic [rv_pkg::xlen-1:0]  pc_plus4
);

    import rv_pkg::*;

    logic [xlen-1:0] target;
    logic [xlen-1:0] next_pc;

    assign pc_plus4 = pc + xlen'(4);
    assign target   = pc + imm;                          // Taken branch or JAL

    always_comb begin
        case (next_pc_sel)
            npc_target: begin
                next_pc = target;
            end
            npc_alu: begin
                next_pc = {alu_result[xlen-1:1], 1'b0};  // JALR clears bit 0
            end
            default: begin
                next_pc = pc_plus4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                      dmem_words = 256
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instr_in,
    output logic [rv_pkg::xlen-1:0]  pc,
    output logic                     rd_write_en,
    output logic [4:0]               rd_addr,
    output logic [rv_pkg::xlen-1:0]  rd_data,
    output logic                     mem_write_en,
    output logic [rv_pkg::xlen-1:0]  mem_addr,
    output logic [rv_pkg::xlen-1:0]  mem_wdata
);

    import rv_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] pc_plus4;
    logic            zero;
    logic            lt;
    logic            ltu;
    alu_op_t         alu_op;
    imm_fmt_t        imm_fmt;
    src_a_sel_t      src_a_sel;
    src_b_sel_t      src_b_sel;
    wb_sel_t         wb_sel;
    next_pc_sel_t    next_pc_sel;

    assign rs1_addr  = instr_in[19:15];
    assign rs2_addr  = instr_in[24:20];
    assign rd_addr   = instr_in[11:7];
    assign mem_addr  = alu_result;                       // Base plus offset
    assign mem_wdata = rs2_data;

    always_comb begin
        case (wb_sel)
            wb_mem:  rd_data = mem_rdata;
            wb_pc4:  rd_data = pc_plus4;                 // Link address
            default: rd_data = alu_result;
        endcase
    end

    control_unit control_unit_inst (
        .instr(instr_in), .zero(zero), .lt(lt), .ltu(ltu), .reset(reset),
        .alu_op(alu_op), .imm_fmt(imm_fmt), .src_a_sel(src_a_sel), .src_b_sel(src_b_sel),
        .wb_sel(wb_sel), .next_pc_sel(next_pc_sel),
        .rd_write_en(rd_write_en), .mem_write_en(mem_write_en)
    );

    imm_gen imm_gen_inst (.instr(instr_in), .imm_fmt(imm_fmt), .imm(imm));

    reg_file reg_file_inst (
        .clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .rd_data(rd_data), .rd_write_en(rd_write_en),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu alu_inst (
        .rs1_data(rs1_data), .pc(pc), .rs2_data(rs2_data), .imm(imm),
        .src_a_sel(src_a_sel), .src_b_sel(src_b_sel), .alu_op(alu_op),
        .alu_result(alu_result), .zero(zero), .lt(lt), .ltu(ltu)
    );

    data_mem #(.dmem_words(dmem_words)) data_mem_inst (
        .clk(clk), .addr(mem_addr), .wdata(mem_wdata),
        .mem_write_en(mem_write_en), .rdata(mem_rdata)
    );

    pc_unit #(.reset_pc(reset_pc)) pc_unit_inst (
        .clk(clk), .reset(reset), .imm(imm), .alu_result(alu_result),
        .next_pc_sel(next_pc_sel), .pc(pc), .pc_plus4(pc_plus4)
    );

endmodule

`default_nettype wire

// File: testbench/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    localparam logic [63:0] reset_pc  = 64'h0;
    localparam int          max_steps = 100;
    localparam int          imm_op    = 'h13;
    localparam int          load_op   = 'h03;
    localparam int          jalr_op   = 'h67;
    localparam logic [31:0] unreached = 32'hfff0_0f93;   // ADDI x31, x0, -1

    logic        clk;
    logic        reset;
    logic [31:0] instr_in;
    logic [63:0] pc;
    logic        rd_write_en;
    logic [4:0]  rd_addr;
    logic [63:0] rd_data;
    logic        mem_write_en;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;

    logic [31:0] t_instr [64];                           // Row index is (pc - reset_pc) / 4
    logic        t_we [64];
    logic [4:0]  t_rd [64];
    logic [63:0] t_rd_data [64];
    logic        t_mwe [64];
    logic [63:0] t_maddr [64];
    logic [63:0] t_mwdata [64];
    logic [63:0] t_npc [64];
    int          n_rows;
    int          err_count;

    core_top core_top_inst (
        .clk(clk), .reset(reset), .instr_in(instr_in), .pc(pc),
        .rd_write_en(rd_write_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .mem_write_en(mem_write_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction
    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction
    function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction
    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic add_row(logic [31:0] instr, int we, int rd, logic [63:0] data, int npc);
        t_instr[n_rows]   = instr;
        t_we[n_rows]      = (we != 0);
        t_rd[n_rows]      = rd[4:0];
        t_rd_data[n_rows] = data;
        t_mwe[n_rows]     = 1'b0;
        t_maddr[n_rows]   = '0;
        t_mwdata[n_rows]  = '0;
        t_npc[n_rows]     = reset_pc + 64'(npc);
        n_rows++;
    endtask

    task automatic mark_store(logic [63:0] addr, logic [63:0] wdata);
        t_mwe[n_rows-1]    = 1'b1;
        t_maddr[n_rows-1]  = addr;
        t_mwdata[n_rows-1] = wdata;
    endtask

    task automatic load_program();
        n_rows = 0;
        add_row(i_type(-5, 0, 0, 1, imm_op), 1, 1, 64'hffff_ffff_ffff_fffb, 4);
        add_row(i_type(3, 0, 0, 2, imm_op), 1, 2, 64'd3, 8);
        add_row(r_type(0, 2, 1, 0, 3), 1, 3, 64'hffff_ffff_ffff_fffe, 12);      // ADD
        add_row(r_type('h20, 2, 1, 0, 4), 1, 4, 64'hffff_ffff_ffff_fff8, 16);   // SUB
        add_row(r_type(0, 2, 1, 7, 5), 1, 5, 64'd3, 20);                        // AND
        add_row(r_type(0, 2, 1, 6, 6), 1, 6, 64'hffff_ffff_ffff_fffb, 24);      // OR
        add_row(r_type(0, 2, 1, 4, 7), 1, 7, 64'hffff_ffff_ffff_fff8, 28);      // XOR
        add_row(r_type(0, 2, 1, 2, 8), 1, 8, 64'd1, 32);                        // SLT
        add_row(r_type(0, 2, 1, 3, 9), 1, 9, 64'd0, 36);                        // SLTU
        add_row(r_type(0, 2, 2, 1, 10), 1, 10, 64'd24, 40);                     // SLL
        add_row(r_type(0, 2, 1, 5, 11), 1, 11, 64'h1fff_ffff_ffff_ffff, 44);    // SRL
        add_row(r_type('h20, 2, 1, 5, 12), 1, 12, 64'hffff_ffff_ffff_ffff, 48); // SRA
        add_row(32'h8000_06b7, 1, 13, 64'hffff_ffff_8000_0000, 52);             // LUI x13
        add_row(32'h0000_1717, 1, 14, reset_pc + 64'h1034, 56);                 // AUIPC x14
        add_row(i_type(7, 0, 0, 0, imm_op), 1, 0, 64'd7, 60);                   // Dropped write
        add_row(r_type(0, 2, 0, 0, 15), 1, 15, 64'd3, 64);                      // x0 reads zero
        add_row(i_type('h40, 0, 0, 16, imm_op), 1, 16, 64'h40, 68);
        add_row(s_type(8, 1, 16), 0, 0, 64'd0, 72);
        mark_store(64'h48, 64'hffff_ffff_ffff_fffb);
        add_row(i_type(8, 16, 3, 17, load_op), 1, 17, 64'hffff_ffff_ffff_fffb, 76);
        add_row(b_type(8, 15, 2, 0), 0, 0, 64'd0, 84);                          // BEQ taken
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(b_type(8, 15, 2, 1), 0, 0, 64'd0, 88);                          // BNE not taken
        add_row(b_type(8, 2, 1, 4), 0, 0, 64'd0, 96);                           // BLT taken
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(b_type(8, 2, 1, 5), 0, 0, 64'd0, 100);                          // BGE not taken
        add_row(b_type(8, 1, 2, 5), 0, 0, 64'd0, 108);                          // BGE taken
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(32'h0080_09ef, 1, 19, reset_pc + 64'd112, 116);                 // JAL x19, +8
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(i_type(129, 0, 0, 20, imm_op), 1, 20, 64'd129, 120);
        add_row(i_type(0, 20, 0, 21, jalr_op), 1, 21, reset_pc + 64'd124, 128);
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(32'h0000_007f, 0, 0, 64'd0, 132);                               // Unknown opcode
        add_row(b_type(8, 2, 1, 0), 0, 0, 64'd0, 136);                          // BEQ not taken
        add_row(b_type(8, 2, 1, 1), 0, 0, 64'd0, 144);                          // BNE taken
        add_row(unreached, 0, 0, 64'd0, 0);
        add_row(r_type(0, 19, 21, 0, 22), 1, 22, 64'd236, 148);                 // Link values
    endtask

    initial begin
        logic [63:0] offset;
        int          idx;
        int          steps;
        bit          done;
        err_count = 0;
        steps     = 0;
        done      = 1'b0;
        reset     = 1'b1;
        instr_in  = i_type(1, 0, 0, 1, imm_op);
        load_program();
        #3;
        for (int i = 0; i < 3; i++) begin
            compare_value("rd_write_en", 64'd0, 64'(rd_write_en));
            compare_value("mem_write_en", 64'd0, 64'(mem_write_en));
            @(posedge clk);
            #1;
            compare_value("pc", reset_pc, pc);
            instr_in = (i % 2 == 0) ? s_type(0, 1, 0) : i_type(1, 0, 0, 1, imm_op);
            if (i < 2) begin
                #6;
            end
        end
        reset = 1'b0;
        while (!done && steps < max_steps) begin
            offset = pc - reset_pc;
            if (!$isunknown(offset) && offset == 64'(4 * n_rows)) begin
                done = 1'b1;
            end else if ($isunknown(offset) || offset[1:0] != 2'b00 ||
                         offset > 64'(4 * n_rows)) begin
                err_count++;
                $display("pc %h left the program table after %0d steps", pc, steps);
                done = 1'b1;
            end else begin
                idx      = int'(offset[7:2]);
                instr_in = t_instr[idx];
                #6;                                      // Just before the next edge
                compare_value("rd_write_en", 64'(t_we[idx]), 64'(rd_write_en));
                if (t_we[idx]) begin
                    compare_value("rd_addr", 64'(t_rd[idx]), 64'(rd_addr));
                    compare_value("rd_data", t_rd_data[idx], rd_data);
                end
                compare_value("mem_write_en", 64'(t_mwe[idx]), 64'(mem_write_en));
                if (t_mwe[idx]) begin
                    compare_value("mem_addr", t_maddr[idx], mem_addr);
                    compare_value("mem_wdata", t_mwdata[idx], mem_wdata);
                end
                @(posedge clk);
                #1;
                compare_value("pc", t_npc[idx], pc);
                steps++;
            end
        end
        if (!done) begin
            err_count++;
            $display("Timeout: program did not reach its end within %0d steps", max_steps);
        end
        $display("Summary: %0d steps, %0d errors", steps, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/rv_pkg.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/pc_unit.sv
hdl/core_top.sv
testbench/tb_core_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_core_top
FILELIST  = filelist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
